/* Bender.yml */
package:
  name: zx_ports

sources:
  - zx_ports_pkg.sv
  - zx_port_decode.sv
  - zx_paging_regs.sv
  - zx_sysconf_regs.sv
  - zx_port_readback.sv
  - zx_ports.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_zx_ports.sv

/* sim.f */
zx_ports_pkg.sv
zx_port_decode.sv
zx_paging_regs.sv
zx_sysconf_regs.sv
zx_port_readback.sv
zx_ports.sv
tb_clock_gen.sv
tb_zx_ports.sv

/* tb_clock_gen.sv */
// free running clock from time zero; reset is held for RESET_CYCLES rising edges only
`timescale 1ns/1ps

module tb_clock_gen
#(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 3
)
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// release a little after the edge, like the other stimulus
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst = 1'b0;
	end

endmodule

/* tb_zx_ports.sv */
// replays zx_ports_trace.txt one access per cycle; input port bytes come from seeded $random
`timescale 1ns/1ps

module tb_zx_ports;

	localparam int MAX_OPS = 128;

	logic        clk;
	logic        rst_por;
	logic        rst_run;
	logic        rst;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iord;
	logic        iowr_s;
	logic        iord_s;
	logic        opfetch;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	logic [7:0]  mus_in;
	logic [7:0]  dout;
	logic        porthit;
	logic        external_port;
	logic        dataout;
	logic        fe_wr;
	logic        covox_wr;
	logic [31:0] xt_page;
	logic [7:0]  memconf;
	logic [7:0]  sysconf;
	logic [3:0]  cacheconf;
	logic [7:0]  intmask;

	// trace contents
	string       op_a   [MAX_OPS];
	logic [15:0] addr_a [MAX_OPS];
	logic [7:0]  data_a [MAX_OPS];
	logic        dos_a  [MAX_OPS];
	string       sig_a  [MAX_OPS];
	logic [7:0]  exp_a  [MAX_OPS];
	int          n_ops;

	int seed;
	int cycles = 0;
	int cycle_limit;

	// power-on reset plus the mid-run reset from the trace
	assign rst = rst_por | rst_run;

	tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) tb_clock_gen_inst
	(
		.clk (clk),
		.rst (rst_por)
	);

	zx_ports zx_ports_inst
	(
		.clk (clk), .rst (rst), .a (a), .din (din), .iord (iord),
		.iowr_s (iowr_s), .iord_s (iord_s), .opfetch (opfetch), .dos (dos),
		.keys_in (keys_in), .tape_read (tape_read), .kj_in (kj_in), .mus_in (mus_in),
		.dout (dout), .porthit (porthit), .external_port (external_port),
		.dataout (dataout), .fe_wr (fe_wr), .covox_wr (covox_wr), .xt_page (xt_page),
		.memconf (memconf), .sysconf (sysconf), .cacheconf (cacheconf), .intmask (intmask)
	);

	task fail_stop(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else fail_stop($sformatf("[FAIL] time %0t: %s is %0h, expected %0h",
			$time, name, got, exp));
	endtask

	// ----------------------------------------
	// trace loading
	// ----------------------------------------

	task automatic load_trace();
		int    fd;
		int    code;
		int    line_no;
		string line;
		string op_s;
		string sig_s;
		logic [15:0] a_v;
		logic [7:0]  d_v;
		logic        dos_v;
		logic [7:0]  e_v;
		fd = $fopen("zx_ports_trace.txt", "r");
		if (fd == 0)
			fail_stop("cannot open the trace file zx_ports_trace.txt");
		n_ops = 0;
		line_no = 0;
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			line_no++;
			// blank lines and # comments carry no access
			if (code > 0 && line.len() > 1 && line.getc(0) != "#")
			begin
				code = $sscanf(line, "%s %h %h %h %s %h", op_s, a_v, d_v, dos_v, sig_s, e_v);
				if (code != 6)
					fail_stop($sformatf("trace line %0d does not have six fields", line_no));
				if (op_s != "W" && op_s != "R" && op_s != "I" && op_s != "O" &&
					op_s != "C" && op_s != "X")
					fail_stop($sformatf("trace line %0d has an unknown operation", line_no));
				if (n_ops >= MAX_OPS)
					fail_stop("trace file holds more operations than the testbench can store");
				op_a[n_ops] = op_s;
				addr_a[n_ops] = a_v;
				data_a[n_ops] = d_v;
				dos_a[n_ops] = dos_v;
				sig_a[n_ops] = sig_s;
				exp_a[n_ops] = e_v;
				n_ops++;
			end
		end
		$fclose(fd);
		if (n_ops == 0)
			fail_stop("trace file holds no operations");
	endtask

	// ----------------------------------------
	// output lookup and expected input bytes
	// ----------------------------------------

	task automatic read_output(input string name, output logic [31:0] val);
		val = '0;
		if (name == "dout") val = dout;
		else if (name == "porthit") val = porthit;
		else if (name == "external_port") val = external_port;
		else if (name == "dataout") val = dataout;
		else if (name == "fe_wr") val = fe_wr;
		else if (name == "covox_wr") val = covox_wr;
		else if (name == "page0") val = xt_page[7:0];
		else if (name == "page1") val = xt_page[15:8];
		else if (name == "page2") val = xt_page[23:16];
		else if (name == "page3") val = xt_page[31:24];
		else if (name == "memconf") val = memconf;
		else if (name == "sysconf") val = sysconf;
		else if (name == "cacheconf") val = cacheconf;
		else if (name == "intmask") val = intmask;
		else fail_stop($sformatf("trace names an unknown output %s", name));
	endtask

	// #FE keyboard and tape, #1F joystick unless dos, #DF mouse
	function automatic logic [7:0] input_port_byte(input logic [7:0] port, input logic dos_v);
		if (port == 8'hFE)
			return {1'b1, tape_read, 1'b1, keys_in};
		if (port == 8'h1F && !dos_v)
			return {3'b000, kj_in};
		if (port == 8'hDF)
			return mus_in;
		return 8'hFF;
	endfunction

	// ----------------------------------------
	// one trace line per cycle
	// ----------------------------------------

	task automatic run_op(input int idx);
		string       op;
		logic [31:0] got;
		logic [31:0] exp;
		op = op_a[idx];
		@(posedge clk);
		#2;
		keys_in = $random(seed);
		tape_read = $random(seed);
		kj_in = $random(seed);
		mus_in = $random(seed);
		a = addr_a[idx];
		din = data_a[idx];
		dos = dos_a[idx];
		iowr_s = 1'b0;
		iord_s = 1'b0;
		iord = 1'b0;
		opfetch = 1'b0;
		if (op == "W")
			iowr_s = 1'b1;
		else if (op == "R" || op == "I")
		begin
			iord = 1'b1;
			iord_s = 1'b1;
		end
		else if (op == "O")
			opfetch = 1'b1;
		if (op == "X")
		begin
			// three edges with reset high
			rst_run = 1'b1;
			repeat (3) @(posedge clk);
			#2 rst_run = 1'b0;
		end
		else if (sig_a[idx] != "-")
		begin
			// sample mid-cycle well clear of both edges
			@(negedge clk);
			read_output(sig_a[idx], got);
			exp = (op == "I") ? input_port_byte(addr_a[idx][7:0], dos_a[idx]) : exp_a[idx];
			check_value(sig_a[idx], got, exp);
		end
	endtask

	// ----------------------------------------
	// cycle limit
	// ----------------------------------------

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycle_limit > 0)
		begin
			assert (cycles < cycle_limit)
			else fail_stop($sformatf("run did not finish within %0d cycles", cycle_limit));
		end
	end

	initial
	begin
		seed = 52;
		cycle_limit = 0;
		rst_run = 1'b0;
		a = '0;
		din = '0;
		iord = 1'b0;
		iowr_s = 1'b0;
		iord_s = 1'b0;
		opfetch = 1'b0;
		dos = 1'b0;
		keys_in = '0;
		tape_read = 1'b0;
		kj_in = '0;
		mus_in = '0;
		load_trace();
		cycle_limit = n_ops * 4 + 50;
		wait (!rst_por);
		for (int i = 0; i < n_ops; i++)
			run_op(i);
		// drop the last strobe before ending
		@(posedge clk);
		#2;
		iowr_s = 1'b0;
		iord_s = 1'b0;
		iord = 1'b0;
		opfetch = 1'b0;
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* zx_paging_regs.sv */
// page 3 is shared by #7FFD and #13AF, whichever writes last wins; lock48 only clears on reset
`timescale 1ns/1ps

module zx_paging_regs
#(
	parameter logic [zx_ports_pkg::BYTE_W-1:0] BANK0_RESET   = 8'h00,
	parameter logic [zx_ports_pkg::BYTE_W-1:0] BANK1_RESET   = 8'h05,
	parameter logic [zx_ports_pkg::BYTE_W-1:0] BANK2_RESET   = 8'h02,
	parameter logic [zx_ports_pkg::BYTE_W-1:0] BANK3_RESET   = 8'h00,
	parameter logic [zx_ports_pkg::BYTE_W-1:0] MEMCONF_RESET = 8'h04
)
(
	input  logic                                                     clk,
	input  logic                                                     rst,
	input  logic                                                     xt_wr,
	input  logic                                                     fd_wr,
	input  logic                                                     opfetch,
	input  logic [zx_ports_pkg::BYTE_W-1:0]                          xt_addr,
	input  logic [zx_ports_pkg::BYTE_W-1:0]                          din,
	output logic [zx_ports_pkg::PAGE_COUNT*zx_ports_pkg::BYTE_W-1:0] xt_page,
	output logic [zx_ports_pkg::BYTE_W-1:0]                          memconf
);

	import zx_ports_pkg::*;

	logic [BYTE_W-1:0] rampage [PAGE_COUNT];

	// lock48 latch, set by #7FFD bit 5
	logic lock48;
	// mode 2 sample taken on each opcode fetch
	logic m1_lock128;

	logic mode2;
	logic mode3;
	logic lock128;
	logic p7ffd_wr;
	logic [BYTE_W-1:0] page3_next;

	// pages packed low to high
	assign xt_page = {rampage[3], rampage[2], rampage[1], rampage[0]};

	// ----------------------------------------
	// lock128 modes from memconf[7:6]
	// ----------------------------------------

	assign mode2 = (memconf[7:6] == 2'b10);
	assign mode3 = (memconf[7:6] == 2'b11);

	// mode 3 never locks, it uses din[5] as a page bit instead
	assign lock128 = mode3 ? 1'b0 : (mode2 ? m1_lock128 : memconf[6]);

	// once lock48 is set the port is dead until reset
	assign p7ffd_wr = fd_wr && !lock48;

	// mode 3 gives 1 mb pentagon style paging
	always_comb
	begin
		if (mode3)
			page3_next = {2'b00, din[5], din[7:6], din[2:0]};
		else
			page3_next = {3'b000, (lock128 ? 2'b00 : din[7:6]), din[2:0]};
	end

	// opcode byte with bits 7 and 6 equal arms the lock
	always_ff @(posedge clk)
	begin
		if (rst)
			m1_lock128 <= 1'b0;
		else if (opfetch)
			m1_lock128 <= !(din[7] ^ din[6]);
	end

	// ----------------------------------------
	// page registers and memconf
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rampage[0] <= BANK0_RESET;
			rampage[1] <= BANK1_RESET;
			rampage[2] <= BANK2_RESET;
			rampage[3] <= BANK3_RESET;
			memconf <= MEMCONF_RESET;
		end
		else if (p7ffd_wr)
		begin
			// rom 48/128 select
			memconf[0] <= din[4];
			rampage[3] <= page3_next;
		end
		else if (xt_wr)
		begin
			// #10..#13 differ only in the two low bits
			if (xt_addr[BYTE_W-1:2] == XT_RAMPAGE[BYTE_W-1:2])
				rampage[xt_addr[1:0]] <= din;
			if (xt_addr == XT_MEMCONF)
				memconf <= din;
		end
	end

	// mode 3 keeps bit 5 as a page bit, no 48k lock there
	always_ff @(posedge clk)
	begin
		if (rst)
			lock48 <= 1'b0;
		else if (p7ffd_wr && !mode3)
			lock48 <= din[5];
	end

endmodule

/* zx_port_decode.sv */
// purely combinational; iowr_s and iord_s must be single clk pulses per cpu access
`timescale 1ns/1ps

module zx_port_decode
(
	input  logic [zx_ports_pkg::ADDR_W-1:0] a,
	input  logic                            iowr_s,
	input  logic                            iord_s,
	input  logic                            iord,
	input  logic                            dos,
	output zx_ports_pkg::port_sel_e         port_sel,
	output logic                            porthit,
	output logic                            external_port,
	output logic                            dataout,
	output logic                            xt_wr,
	output logic                            xt_rd,
	output logic                            fd_wr,
	output logic                            fe_wr,
	output logic                            covox_wr
);

	import zx_ports_pkg::*;

	// low byte selects the port
	logic [BYTE_W-1:0] loa;

	assign loa = a[BYTE_W-1:0];

	// ----------------------------------------
	// port classification
	// ----------------------------------------

	always_comb
	begin
		case (loa)
			PORT_FE:     port_sel = SEL_FE;
			PORT_FD:     port_sel = SEL_FD;
			PORT_XT:     port_sel = SEL_XT;
			PORT_COVOX:  port_sel = SEL_COVOX;
			// joystick shares #1F with the fdc, so dos hides it
			PORT_KJOY:   port_sel = dos ? SEL_NONE : SEL_KJOY;
			PORT_KMOUSE: port_sel = SEL_KMOUSE;
			default:     port_sel = SEL_NONE;
		endcase
	end

	assign porthit = (port_sel != SEL_NONE);

	// sound chip sits on #FD with a15 set, handled off-chip
	assign external_port = (port_sel == SEL_FD) && a[ADDR_W-1];

	// drive the cpu bus only for our own ports
	assign dataout = porthit && iord && !external_port;

	// ----------------------------------------
	// strobes
	// ----------------------------------------

	assign xt_wr = (port_sel == SEL_XT) && iowr_s;
	assign xt_rd = (port_sel == SEL_XT) && iord_s;

	// #7FFD, lock48 gating happens in the paging block
	assign fd_wr = (port_sel == SEL_FD) && !a[ADDR_W-1] && iowr_s;

	// border and beeper
	assign fe_wr = (port_sel == SEL_FE) && iowr_s;
	assign covox_wr = (port_sel == SEL_COVOX) && iowr_s;

endmodule

/* zx_port_readback.sv */
// combinational read mux; unmapped ports and extended registers read as #FF
`timescale 1ns/1ps

module zx_port_readback
(
	input  zx_ports_pkg::port_sel_e                                  port_sel,
	input  logic [zx_ports_pkg::BYTE_W-1:0]                          xt_addr,
	input  logic [zx_ports_pkg::PAGE_COUNT*zx_ports_pkg::BYTE_W-1:0] xt_page,
	input  logic                                                     pwr_up,
	input  logic                                                     tape_read,
	input  logic [4:0]                                               keys_in,
	input  logic [4:0]                                               kj_in,
	input  logic [zx_ports_pkg::BYTE_W-1:0]                          mus_in,
	output logic [zx_ports_pkg::BYTE_W-1:0]                          dout
);

	import zx_ports_pkg::*;

	// ----------------------------------------
	// extended register readback
	// ----------------------------------------

	logic [BYTE_W-1:0] xt_dout;

	always_comb
	begin
		case (xt_addr)
			// low bits 000011 report the board revision
			XT_XSTAT:
				xt_dout = {1'b0, pwr_up, 6'b000011};
			// only the upper two pages read back
			XT_RAMPAGE + 8'd2,
			XT_RAMPAGE + 8'd3:
				xt_dout = xt_page[xt_addr[1:0]*BYTE_W +: BYTE_W];
			default:
				xt_dout = 8'hFF;
		endcase
	end

	// ----------------------------------------
	// port mux
	// ----------------------------------------

	always_comb
	begin
		case (port_sel)
			// bit 5 reads high like a real issue 3 board
			SEL_FE:
				dout = {1'b1, tape_read, 1'b1, keys_in};
			SEL_XT:
				dout = xt_dout;
			// kempston, fire and directions
			SEL_KJOY:
				dout = {3'b000, kj_in};
			SEL_KMOUSE:
				dout = mus_in;
			// #FD and covox are write only
			default:
				dout = 8'hFF;
		endcase
	end

endmodule

/* zx_ports.sv */
// single clock domain; cpu accesses arrive as one-cycle iowr_s and iord_s pulses on clk
`timescale 1ns/1ps

module zx_ports
#(
	parameter logic [zx_ports_pkg::BYTE_W-1:0] BANK0_RESET   = 8'h00,
	parameter logic [zx_ports_pkg::BYTE_W-1:0] BANK1_RESET   = 8'h05,
	parameter logic [zx_ports_pkg::BYTE_W-1:0] BANK2_RESET   = 8'h02,
	parameter logic [zx_ports_pkg::BYTE_W-1:0] BANK3_RESET   = 8'h00,
	parameter logic [zx_ports_pkg::BYTE_W-1:0] MEMCONF_RESET = 8'h04,
	parameter logic [zx_ports_pkg::BYTE_W-1:0] SYSCONF_RESET = 8'h01,
	parameter logic [zx_ports_pkg::BYTE_W-1:0] INTMASK_RESET = 8'h01
)
(
	input  logic                                                     clk,
	input  logic                                                     rst,
	input  logic [zx_ports_pkg::ADDR_W-1:0]                          a,
	input  logic [zx_ports_pkg::BYTE_W-1:0]                          din,
	input  logic                                                     iord,
	input  logic                                                     iowr_s,
	input  logic                                                     iord_s,
	input  logic                                                     opfetch,
	input  logic                                                     dos,
	input  logic [4:0]                                               keys_in,
	input  logic                                                     tape_read,
	input  logic [4:0]                                               kj_in,
	input  logic [zx_ports_pkg::BYTE_W-1:0]                          mus_in,
	output logic [zx_ports_pkg::BYTE_W-1:0]                          dout,
	output logic                                                     porthit,
	output logic                                                     external_port,
	output logic                                                     dataout,
	output logic                                                     fe_wr,
	output logic                                                     covox_wr,
	output logic [zx_ports_pkg::PAGE_COUNT*zx_ports_pkg::BYTE_W-1:0] xt_page,
	output logic [zx_ports_pkg::BYTE_W-1:0]                          memconf,
	output logic [zx_ports_pkg::BYTE_W-1:0]                          sysconf,
	output logic [zx_ports_pkg::CACHE_W-1:0]                         cacheconf,
	output logic [zx_ports_pkg::BYTE_W-1:0]                          intmask
);

	import zx_ports_pkg::*;

	port_sel_e port_sel;
	logic      xt_wr;
	logic      xt_rd;
	logic      fd_wr;
	logic      pwr_up;

	// ----------------------------------------
	// decode
	// ----------------------------------------

	zx_port_decode zx_port_decode_inst
	(
		.a             (a),
		.iowr_s        (iowr_s),
		.iord_s        (iord_s),
		.iord          (iord),
		.dos           (dos),
		.port_sel      (port_sel),
		.porthit       (porthit),
		.external_port (external_port),
		.dataout       (dataout),
		.xt_wr         (xt_wr),
		.xt_rd         (xt_rd),
		.fd_wr         (fd_wr),
		.fe_wr         (fe_wr),
		.covox_wr      (covox_wr)
	);

	// ----------------------------------------
	// register blocks
	// ----------------------------------------

	// high address byte picks the extended register
	zx_paging_regs
	#(
		.BANK0_RESET   (BANK0_RESET),
		.BANK1_RESET   (BANK1_RESET),
		.BANK2_RESET   (BANK2_RESET),
		.BANK3_RESET   (BANK3_RESET),
		.MEMCONF_RESET (MEMCONF_RESET)
	)
	zx_paging_regs_inst
	(
		.clk     (clk),
		.rst     (rst),
		.xt_wr   (xt_wr),
		.fd_wr   (fd_wr),
		.opfetch (opfetch),
		.xt_addr (a[ADDR_W-1:BYTE_W]),
		.din     (din),
		.xt_page (xt_page),
		.memconf (memconf)
	);

	zx_sysconf_regs
	#(
		.SYSCONF_RESET (SYSCONF_RESET),
		.INTMASK_RESET (INTMASK_RESET)
	)
	zx_sysconf_regs_inst
	(
		.clk       (clk),
		.rst       (rst),
		.xt_wr     (xt_wr),
		.xt_rd     (xt_rd),
		.xt_addr   (a[ADDR_W-1:BYTE_W]),
		.din       (din),
		.sysconf   (sysconf),
		.cacheconf (cacheconf),
		.intmask   (intmask),
		.pwr_up    (pwr_up)
	);

	// ----------------------------------------
	// read mux
	// ----------------------------------------

	zx_port_readback zx_port_readback_inst
	(
		.port_sel  (port_sel),
		.xt_addr   (a[ADDR_W-1:BYTE_W]),
		.xt_page   (xt_page),
		.pwr_up    (pwr_up),
		.tape_read (tape_read),
		.keys_in   (keys_in),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.dout      (dout)
	);

endmodule

/* zx_ports_pkg.sv */
// all decode uses the low address byte only and extended registers match the high byte exactly
package zx_ports_pkg;

	// ----------------------------------------
	// field widths
	// ----------------------------------------

	// cpu data bus
	localparam int BYTE_W = 8;
	// cpu address bus
	localparam int ADDR_W = 16;
	// ram page registers behind #10..#13
	localparam int PAGE_COUNT = 4;
	// cache enable bits, one per 16k window
	localparam int CACHE_W = 4;

	// ----------------------------------------
	// i/o ports, low address byte
	// ----------------------------------------

	// border, beeper, keyboard and tape
	localparam logic [BYTE_W-1:0] PORT_FE = 8'hFE;
	// #7FFD paging with a15 low, sound chip with a15 high
	localparam logic [BYTE_W-1:0] PORT_FD = 8'hFD;
	// extended config space, register number in a[15:8]
	localparam logic [BYTE_W-1:0] PORT_XT = 8'hAF;
	// covox dac
	localparam logic [BYTE_W-1:0] PORT_COVOX = 8'hFB;
	// kempston joystick, hidden while dos rom is on
	localparam logic [BYTE_W-1:0] PORT_KJOY = 8'h1F;
	// kempston mouse
	localparam logic [BYTE_W-1:0] PORT_KMOUSE = 8'hDF;

	// ----------------------------------------
	// extended registers, high address byte
	// ----------------------------------------

	// status byte, read only
	localparam logic [BYTE_W-1:0] XT_XSTAT = 8'h00;
	// base of the four page registers
	localparam logic [BYTE_W-1:0] XT_RAMPAGE = 8'h10;
	localparam logic [BYTE_W-1:0] XT_SYSCONF = 8'h20;
	localparam logic [BYTE_W-1:0] XT_MEMCONF = 8'h21;
	localparam logic [BYTE_W-1:0] XT_INTMASK = 8'h2A;
	localparam logic [BYTE_W-1:0] XT_CACHECONF = 8'h2B;

	// ----------------------------------------
	// port select
	// ----------------------------------------

	// one value per decoded port
	// SEL_NONE means no internal port is hit
	typedef enum logic [2:0]
	{
		SEL_NONE,
		SEL_FE,
		SEL_FD,
		SEL_XT,
		SEL_COVOX,
		SEL_KJOY,
		SEL_KMOUSE
	} port_sel_e;

endpackage

/* zx_ports_trace.txt */
# op addr data dos output expected (hex); op: W write, R read, I input port read, O opfetch,
# C check without strobe, X reset; output - compares nothing, I derives its expected byte
C 0000 00 0 page0 00
C 0000 00 0 page1 05
C 0000 00 0 page2 02
C 0000 00 0 page3 00
C 0000 00 0 memconf 04
C 0000 00 0 sysconf 01
C 0000 00 0 cacheconf 00
C 0000 00 0 intmask 01
R 00AF 00 0 dout 43
R 00AF 00 0 dout 03
W 10AF 12 0 - 00
C 0000 00 0 page0 12
W 11AF 34 0 - 00
C 0000 00 0 page1 34
W 12AF 56 0 - 00
C 0000 00 0 page2 56
W 13AF 07 0 - 00
C 0000 00 0 page3 07
R 12AF 00 0 dout 56
R 13AF 00 0 dout 07
R 10AF 00 0 dout FF
R 2AAF 00 0 dout FF
W 2AAF A5 0 - 00
C 0000 00 0 intmask A5
W 2BAF 0A 0 - 00
C 0000 00 0 cacheconf 0A
W 20AF 04 0 - 00
C 0000 00 0 sysconf 04
C 0000 00 0 cacheconf 0F
W 7FFD D3 0 - 00
C 0000 00 0 memconf 05
C 0000 00 0 page3 1B
W 21AF 44 0 - 00
W 7FFD C5 0 - 00
C 0000 00 0 page3 05
W 21AF C0 0 - 00
W 7FFD 66 0 - 00
C 0000 00 0 page3 2E
W 7FFD 07 0 - 00
C 0000 00 0 page3 07
W 21AF 80 0 - 00
W 7FFD C2 0 - 00
C 0000 00 0 page3 1A
O 0000 3E 0 - 00
W 7FFD C2 0 - 00
C 0000 00 0 page3 02
O 0000 7E 0 - 00
W 7FFD 81 0 - 00
C 0000 00 0 page3 11
W 21AF 04 0 - 00
W 7FFD 23 0 - 00
C 0000 00 0 page3 03
W 7FFD D7 0 - 00
C 0000 00 0 page3 03
C 0000 00 0 memconf 04
I 00FE 00 0 dout 00
I 001F 00 0 dout 00
I 00DF 00 0 dout 00
R 001F 00 1 dout FF
R 001F 00 1 porthit 0
R 001F 00 0 porthit 1
R FFFD 00 0 external_port 1
R FFFD 00 0 dataout 0
R 7FFD 00 0 dataout 1
W 00FE 07 0 fe_wr 1
C 00FE 00 0 fe_wr 0
W 00FB 80 0 covox_wr 1
C 00FB 00 0 covox_wr 0
W 00FB 80 0 fe_wr 0
W 00DF 00 0 covox_wr 0
R 00FE 00 0 fe_wr 0
X 0000 00 0 - 00
C 0000 00 0 page0 00
C 0000 00 0 page3 00
C 0000 00 0 memconf 04
C 0000 00 0 sysconf 01
C 0000 00 0 cacheconf 00
C 0000 00 0 intmask 01
R 00AF 00 0 dout 03
W 7FFD 12 0 - 00
C 0000 00 0 page3 02
C 0000 00 0 memconf 05

/* zx_sysconf_regs.sv */
// power-up flag is set only by fpga configuration and survives rst; needs a target with init values
`timescale 1ns/1ps

module zx_sysconf_regs
#(
	parameter logic [zx_ports_pkg::BYTE_W-1:0] SYSCONF_RESET = 8'h01,
	parameter logic [zx_ports_pkg::BYTE_W-1:0] INTMASK_RESET = 8'h01
)
(
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             xt_wr,
	input  logic                             xt_rd,
	input  logic [zx_ports_pkg::BYTE_W-1:0]  xt_addr,
	input  logic [zx_ports_pkg::BYTE_W-1:0]  din,
	output logic [zx_ports_pkg::BYTE_W-1:0]  sysconf,
	output logic [zx_ports_pkg::CACHE_W-1:0] cacheconf,
	output logic [zx_ports_pkg::BYTE_W-1:0]  intmask,
	output logic                             pwr_up
);

	import zx_ports_pkg::*;

	// loaded as 1 by configuration
	logic pwr_up_q = 1'b1;

	assign pwr_up = pwr_up_q;

	// ----------------------------------------
	// config registers
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sysconf <= SYSCONF_RESET;
			// cache off after reset
			cacheconf <= '0;
			intmask <= INTMASK_RESET;
		end
		else if (xt_wr)
		begin
			// sysconf bit 2 is the global cache enable
			if (xt_addr == XT_SYSCONF)
			begin
				sysconf <= din;
				cacheconf <= {CACHE_W{din[2]}};
			end
			// per window cache enables
			if (xt_addr == XT_CACHECONF)
				cacheconf <= din[CACHE_W-1:0];
			if (xt_addr == XT_INTMASK)
				intmask <= din;
		end
	end

	// ----------------------------------------
	// power-up flag
	// ----------------------------------------

	// first status read clears it for good
	always_ff @(posedge clk)
	begin
		if (xt_rd && (xt_addr == XT_XSTAT))
			pwr_up_q <= 1'b0;
	end

endmodule
